//--- include/vmem_defs_defs.svh
////////////////////
// global sizes for the memory copy subsystem
// data width, RAM depth, response latency, count width
////////////////////

`ifndef VMEM_DEFS_DEFS_SVH
`define VMEM_DEFS_DEFS_SVH

// width of one data word in bits
`define VMEM_DATA_W 32

`define VMEM_DEPTH 256   // words in the RAM

// cycles from request to response, at least 1
`define VMEM_LATENCY 2

`define VMEM_CNT_W 9     // wide enough to hold VMEM_DEPTH

`endif

//--- logic/vmem_bus_pkg.sv
////////////////////
// request/response bus types
////////////////////

`include "vmem_defs_defs.svh"

package vmem_bus_pkg;

    typedef logic [`VMEM_DATA_W-1:0]   word_t;
    typedef logic [31:0]               addr_t;  // byte address
    typedef logic [`VMEM_DATA_W/8-1:0] be_t;

    // one request, sampled when req is high
    typedef struct packed {
        logic  req;
        logic  we;
        be_t   be;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // response strobe, fixed latency after the request
    typedef struct packed {
        logic  valid;
        logic  err;     // address out of range
        word_t rdata;
    } mem_rsp_t;

endpackage

//--- logic/vmem_ctrl_pkg.sv
////////////////////
// copy controller types
////////////////////

`include "vmem_defs_defs.svh"

package vmem_ctrl_pkg;

    typedef logic [`VMEM_CNT_W-1:0] cnt_t;  // word count

    typedef enum logic [2:0] {
        IDLE,
        RD_REQ,
        RD_WAIT,
        WR_REQ,
        WR_WAIT,
        DONE
    } copy_state_e;

    // block copy job, addresses in bytes
    typedef struct packed {
        vmem_bus_pkg::addr_t src;
        vmem_bus_pkg::addr_t dst;
        cnt_t                len;    // in words
    } copy_cmd_t;

endpackage

//--- logic/vmem_latency_ram.sv
////////////////////
// byte-enabled RAM with fixed-latency response
// and out-of-range error flag
////////////////////

`timescale 1ns/1ps
`include "vmem_defs_defs.svh"

module vmem_latency_ram (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  vmem_bus_pkg::mem_req_t req_i,
    output vmem_bus_pkg::mem_rsp_t rsp_o
);

    localparam int unsigned NB    = `VMEM_DATA_W / 8;
    localparam int unsigned OFS_W = $clog2(NB);
    localparam int unsigned IDX_W = $clog2(`VMEM_DEPTH);
    localparam int unsigned AW    = $bits(vmem_bus_pkg::addr_t);

    vmem_bus_pkg::word_t mem_q [`VMEM_DEPTH];

    logic [IDX_W-1:0]    idx;
    logic                oor;
    vmem_bus_pkg::word_t rdata;

    // response pipeline, stage LATENCY-1 drives the output
    logic                vld_q   [`VMEM_LATENCY];
    logic                err_q   [`VMEM_LATENCY];
    vmem_bus_pkg::word_t rdata_q [`VMEM_LATENCY];

    assign idx   = req_i.addr[OFS_W +: IDX_W];   // low bits ignored
    assign oor   = (req_i.addr[AW-1:OFS_W+IDX_W] != '0);
    assign rdata = oor ? '0 : mem_q[idx];

    // write lands at the sampling edge
    always_ff @(posedge clk) begin
        if (req_i.req && req_i.we && !oor) begin
            for (int i = 0; i < NB; i++) begin
                if (req_i.be[i]) begin
                    mem_q[idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `VMEM_LATENCY; i++) begin
                vld_q[i] <= 1'b0;
            end
        end else begin
            vld_q[0] <= req_i.req;
            for (int i = 1; i < `VMEM_LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // payload follows the valid bit
    always_ff @(posedge clk) begin
        err_q[0]   <= req_i.req & oor;
        rdata_q[0] <= rdata;    // old word, read before the write lands
        for (int i = 1; i < `VMEM_LATENCY; i++) begin
            err_q[i]   <= err_q[i-1];
            rdata_q[i] <= rdata_q[i-1];
        end
    end

    assign rsp_o.valid = vld_q[`VMEM_LATENCY-1];
    assign rsp_o.err   = err_q[`VMEM_LATENCY-1];
    assign rsp_o.rdata = rdata_q[`VMEM_LATENCY-1];

    // host and copy engine must never leave the strobe floating
    a_req_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(req_i.req)
    );

    // an empty write would still produce a response, most likely a bug upstream
    a_be_on_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (req_i.req && req_i.we) |-> (req_i.be != '0)
    );

endmodule

//--- logic/vmem_word_counter.sv
////////////////////
// remaining-word and offset counter
////////////////////

`timescale 1ns/1ps

module vmem_word_counter (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                load_i,
    input  vmem_ctrl_pkg::cnt_t len_i,
    input  logic                step_i,
    output vmem_ctrl_pkg::cnt_t offset_o,
    output logic                last_o,
    output logic                empty_o
);

    vmem_ctrl_pkg::cnt_t remain_q;
    vmem_ctrl_pkg::cnt_t offset_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            remain_q <= '0;
            offset_q <= '0;
        end else if (load_i) begin
            remain_q <= len_i;
            offset_q <= '0;
        end else if (step_i) begin
            remain_q <= remain_q - 1'b1;
            offset_q <= offset_q + 1'b1;
        end
    end

    assign offset_o = offset_q;
    assign last_o   = (remain_q == vmem_ctrl_pkg::cnt_t'(1));
    assign empty_o  = (remain_q == '0);

    // the FSM must stop stepping once all words are done
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        step_i |-> !empty_o
    );

endmodule

//--- logic/vmem_copy_fsm.sv
////////////////////
// copy controller FSM
// forwards host requests while idle
////////////////////

`timescale 1ns/1ps

module vmem_copy_fsm (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  vmem_ctrl_pkg::copy_cmd_t cmd_i,
    input  vmem_bus_pkg::mem_req_t   host_req_i,
    input  vmem_bus_pkg::mem_rsp_t   rsp_i,
    input  vmem_ctrl_pkg::cnt_t      offset_i,
    input  logic                     last_i,
    input  logic                     empty_i,
    output logic                     load_o,
    output logic                     step_o,
    output vmem_bus_pkg::mem_req_t   req_o,
    output logic                     busy_o,
    output logic                     done_o,
    output logic                     err_o
);

    vmem_ctrl_pkg::copy_state_e state_q, state_d;
    vmem_ctrl_pkg::copy_cmd_t   cmd_q;
    vmem_bus_pkg::word_t        wdata_q;
    logic                       err_q, err_d;
    vmem_bus_pkg::addr_t        byte_ofs;
    vmem_bus_pkg::mem_req_t     own_req;

    assign byte_ofs = vmem_bus_pkg::addr_t'(offset_i) << 2;  // word offset to bytes

    always_comb begin
        state_d = state_q;
        err_d   = err_q;
        load_o  = 1'b0;
        step_o  = 1'b0;
        case (state_q)
            vmem_ctrl_pkg::IDLE: begin
                if (start_i) begin
                    state_d = vmem_ctrl_pkg::RD_REQ;
                    load_o  = 1'b1;
                    err_d   = 1'b0;     // error holds only until the next job
                end
            end
            vmem_ctrl_pkg::RD_REQ: begin
                // zero length ends here without touching memory
                state_d = empty_i ? vmem_ctrl_pkg::DONE : vmem_ctrl_pkg::RD_WAIT;
            end
            vmem_ctrl_pkg::RD_WAIT: begin
                if (rsp_i.valid) begin
                    if (rsp_i.err) begin
                        state_d = vmem_ctrl_pkg::DONE;
                        err_d   = 1'b1;
                    end else begin
                        state_d = vmem_ctrl_pkg::WR_REQ;
                    end
                end
            end
            vmem_ctrl_pkg::WR_REQ: begin
                state_d = vmem_ctrl_pkg::WR_WAIT;
            end
            vmem_ctrl_pkg::WR_WAIT: begin
                if (rsp_i.valid) begin
                    step_o = 1'b1;
                    if (rsp_i.err) begin
                        state_d = vmem_ctrl_pkg::DONE;
                        err_d   = 1'b1;
                    end else if (last_i) begin
                        state_d = vmem_ctrl_pkg::DONE;
                    end else begin
                        state_d = vmem_ctrl_pkg::RD_REQ;
                    end
                end
            end
            vmem_ctrl_pkg::DONE: begin
                state_d = vmem_ctrl_pkg::IDLE;
            end
            default: begin
                state_d = vmem_ctrl_pkg::IDLE;
            end
        endcase
    end

    // engine side of the bus
    always_comb begin
        own_req = '0;
        case (state_q)
            vmem_ctrl_pkg::RD_REQ: begin
                own_req.req  = !empty_i;
                own_req.addr = cmd_q.src + byte_ofs;
            end
            vmem_ctrl_pkg::WR_REQ: begin
                own_req.req   = 1'b1;
                own_req.we    = 1'b1;
                own_req.be    = '1;
                own_req.addr  = cmd_q.dst + byte_ofs;
                own_req.wdata = wdata_q;
            end
            default: ;
        endcase
    end

    assign req_o = (state_q == vmem_ctrl_pkg::IDLE) ? host_req_i : own_req;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= vmem_ctrl_pkg::IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            err_q   <= err_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == vmem_ctrl_pkg::IDLE && start_i) begin
            cmd_q <= cmd_i;
        end
        if (state_q == vmem_ctrl_pkg::RD_WAIT && rsp_i.valid) begin
            wdata_q <= rsp_i.rdata;     // becomes the write payload
        end
    end

    assign busy_o = (state_q != vmem_ctrl_pkg::IDLE);
    assign done_o = (state_q == vmem_ctrl_pkg::DONE);
    assign err_o  = err_q;

    // a start during a copy would be dropped silently
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        start_i |-> !busy_o
    );

endmodule

//--- logic/vmem_copy_top.sv
////////////////////
// copy engine top level
////////////////////

`timescale 1ns/1ps

module vmem_copy_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  vmem_ctrl_pkg::copy_cmd_t cmd_i,
    input  vmem_bus_pkg::mem_req_t   host_req_i,
    output vmem_bus_pkg::mem_rsp_t   host_rsp_o,
    output logic                     busy_o,
    output logic                     done_o,
    output logic                     err_o
);

    vmem_bus_pkg::mem_req_t mem_req;
    vmem_bus_pkg::mem_rsp_t mem_rsp;
    vmem_ctrl_pkg::cnt_t    offset;
    logic                   load;
    logic                   step;
    logic                   last;
    logic                   empty;

    vmem_copy_fsm i_fsm (
        .clk        ( clk        ),
        .rst_n_i    ( rst_n_i    ),
        .start_i    ( start_i    ),
        .cmd_i      ( cmd_i      ),
        .host_req_i ( host_req_i ),
        .rsp_i      ( mem_rsp    ),
        .offset_i   ( offset     ),
        .last_i     ( last       ),
        .empty_i    ( empty      ),
        .load_o     ( load       ),
        .step_o     ( step       ),
        .req_o      ( mem_req    ),
        .busy_o     ( busy_o     ),
        .done_o     ( done_o     ),
        .err_o      ( err_o      )
    );

    vmem_word_counter i_cnt (
        .clk      ( clk          ),
        .rst_n_i  ( rst_n_i      ),
        .load_i   ( load         ),
        .len_i    ( cmd_i.len    ),  // sampled together with start_i
        .step_i   ( step         ),
        .offset_o ( offset       ),
        .last_o   ( last         ),
        .empty_o  ( empty        )
    );

    vmem_latency_ram i_ram (
        .clk     ( clk     ),
        .rst_n_i ( rst_n_i ),
        .req_i   ( mem_req ),
        .rsp_o   ( mem_rsp )
    );

    assign host_rsp_o = mem_rsp;     // host sees every response

endmodule

//--- sim/vmem_copy_tb.sv
////////////////////
// directed testbench for the memory copy subsystem
// reference memory model, host and copy tasks
////////////////////

`timescale 1ns/1ps
`include "vmem_defs_defs.svh"

module vmem_copy_tb;

    localparam int unsigned N_RW       = 32;
    localparam int unsigned MAX_LEN    = 32;
    localparam int unsigned EDGE_LEN   = 16;
    localparam int unsigned EDGE_DST   = `VMEM_DEPTH - 8;    // copy crosses the top after 8 words
    localparam int unsigned HOST_OPS   = `VMEM_DEPTH + 2*N_RW + 2*MAX_LEN + 32;
    localparam int unsigned COPY_WORDS = MAX_LEN + EDGE_LEN;
    localparam int unsigned CYCLE_LIMIT = (HOST_OPS + COPY_WORDS) * 2 * (`VMEM_LATENCY + 1) + 200;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     start;
    vmem_ctrl_pkg::copy_cmd_t cmd;
    vmem_bus_pkg::mem_req_t   host_req;
    vmem_bus_pkg::mem_rsp_t   host_rsp;
    logic                     busy;
    logic                     done;
    logic                     err;

    vmem_bus_pkg::word_t ref_mem [`VMEM_DEPTH];   // expected RAM contents
    logic [31:0]         rng_q;
    int unsigned         value_errs;
    int unsigned         other_errs;
    int unsigned         cycle_cnt = 0;

    vmem_copy_top i_dut (
        .clk        ( clk      ),
        .rst_n_i    ( rst_n    ),
        .start_i    ( start    ),
        .cmd_i      ( cmd      ),
        .host_req_i ( host_req ),
        .host_rsp_o ( host_rsp ),
        .busy_o     ( busy     ),
        .done_o     ( done     ),
        .err_o      ( err      )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // xorshift32
    function automatic logic [31:0] rand32();
        rng_q ^= rng_q << 13;
        rng_q ^= rng_q >> 17;
        rng_q ^= rng_q << 5;
        return rng_q;
    endfunction

    function automatic vmem_bus_pkg::word_t fill_word(input int unsigned idx);
        return (idx * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            other_errs++;
            $display("%s", what);
        end
    endtask

    // drives one host access and returns at the falling edge that shows the response
    task automatic host_access(input logic we, input vmem_bus_pkg::be_t be,
                               input vmem_bus_pkg::addr_t addr, input vmem_bus_pkg::word_t wdata,
                               output vmem_bus_pkg::mem_rsp_t rsp);
        int unsigned waited;
        host_req.req   = 1'b1;
        host_req.we    = we;
        host_req.be    = be;
        host_req.addr  = addr;
        host_req.wdata = wdata;
        @(negedge clk);
        host_req = '0;
        waited   = 1;
        while (!host_rsp.valid && waited < 4*`VMEM_LATENCY + 4) begin
            @(negedge clk);
            waited++;
        end
        rsp = host_rsp;
        expect_true(host_rsp.valid && waited == `VMEM_LATENCY,
            $sformatf("response to 0x%h came after %0d cycles or never", addr, waited));
    endtask

    task automatic write_word(input vmem_bus_pkg::addr_t addr, input vmem_bus_pkg::be_t be,
                              input vmem_bus_pkg::word_t data);
        vmem_bus_pkg::mem_rsp_t rsp;
        int unsigned            idx;
        idx = addr >> 2;
        host_access(1'b1, be, addr, data, rsp);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
        end
        expect_eq("rsp.err", rsp.err, 0);
    endtask

    task automatic read_check(input vmem_bus_pkg::addr_t addr);
        vmem_bus_pkg::mem_rsp_t rsp;
        host_access(1'b0, '0, addr, '0, rsp);
        expect_eq("rsp.err", rsp.err, 0);
        expect_eq($sformatf("rsp.rdata @0x%h", addr), rsp.rdata, ref_mem[addr >> 2]);
    endtask

    // words past the top are dropped since the engine stops there
    task automatic model_copy(input int unsigned src_idx, input int unsigned dst_idx,
                              input int unsigned len);
        for (int i = 0; i < len; i++) begin
            if (dst_idx + i < `VMEM_DEPTH) ref_mem[dst_idx + i] = ref_mem[src_idx + i];
        end
    endtask

    task automatic run_copy(input int unsigned src_idx, input int unsigned dst_idx,
                            input int unsigned len, output logic copy_err,
                            output int unsigned waited);
        int unsigned bound;
        bound     = len * 2 * (`VMEM_LATENCY + 1) + 2;
        cmd.src   = src_idx * 4;
        cmd.dst   = dst_idx * 4;
        cmd.len   = vmem_ctrl_pkg::cnt_t'(len);
        start     = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        waited = 1;
        while (!done && waited < bound) begin
            expect_true(busy, "busy_o low while the copy runs");
            @(negedge clk);
            waited++;
        end
        expect_true(done, $sformatf("done_o did not come within %0d cycles", bound));
        expect_true(busy, "busy_o low in the done_o cycle");
        copy_err = err;
        @(negedge clk);
        expect_true(!done && !busy, "done_o or busy_o still high after the done_o cycle");
    endtask

    task automatic reset_idle_check();
        expect_true(!busy && !done && !err, "busy_o, done_o or err_o high after reset");
        expect_true(!host_rsp.valid, "response valid high after reset");
    endtask

    task automatic host_rw_random();
        int unsigned       idx;
        vmem_bus_pkg::be_t be;
        for (int n = 0; n < N_RW; n++) begin
            idx = rand32() % `VMEM_DEPTH;
            be  = vmem_bus_pkg::be_t'(rand32());
            if (be == '0) be = 4'h1;    // empty writes are illegal
            write_word(idx * 4, be, rand32());
            read_check(idx * 4);
        end
    endtask

    task automatic host_out_of_range();
        int unsigned            idx;
        vmem_bus_pkg::mem_rsp_t rsp;
        idx = rand32() % `VMEM_DEPTH;
        host_access(1'b0, '0, (`VMEM_DEPTH + idx) * 4, '0, rsp);
        expect_eq("rsp.err", rsp.err, 1);
        expect_eq("rsp.rdata", rsp.rdata, 0);
        // same low bits as idx with the top address bit set
        host_access(1'b1, 4'hf, 32'h8000_0000 | (idx << 2), ~ref_mem[idx], rsp);
        expect_eq("rsp.err", rsp.err, 1);
        read_check(idx * 4);
    endtask

    task automatic block_copy();
        int unsigned src_idx;
        int unsigned dst_idx;
        int unsigned len;
        int unsigned waited;
        logic        copy_err;
        len     = 1 + rand32() % MAX_LEN;
        src_idx = rand32() % 64;
        dst_idx = 128 + rand32() % 64;
        for (int i = 0; i < len; i++) write_word((src_idx + i) * 4, 4'hf, rand32());
        run_copy(src_idx, dst_idx, len, copy_err, waited);
        expect_eq("err_o", copy_err, 0);
        model_copy(src_idx, dst_idx, len);
        for (int i = 0; i < len; i++) read_check((dst_idx + i) * 4);
    endtask

    task automatic zero_length_copy();
        int unsigned dst_idx;
        int unsigned waited;
        logic        copy_err;
        dst_idx = 128 + rand32() % 64;
        run_copy(0, dst_idx, 0, copy_err, waited);
        expect_true(waited == 2,
            $sformatf("done_o came %0d cycles after start_i instead of 2", waited));
        expect_eq("err_o", copy_err, 0);
        for (int i = 0; i < 4; i++) read_check((dst_idx + i) * 4);
    endtask

    task automatic copy_past_end();
        int unsigned src_idx;
        int unsigned waited;
        int unsigned stop_at;
        logic        copy_err;
        src_idx = rand32() % 64;
        stop_at = (`VMEM_DEPTH - EDGE_DST + 1) * 2 * (`VMEM_LATENCY + 1) + 1;  // failing word ends it
        run_copy(src_idx, EDGE_DST, EDGE_LEN, copy_err, waited);
        expect_true(waited == stop_at,
            $sformatf("done_o came %0d cycles after start_i instead of %0d", waited, stop_at));
        expect_eq("err_o", copy_err, 1);
        expect_eq("err_o after done", err, 1);   // holds until the next start
        model_copy(src_idx, EDGE_DST, EDGE_LEN);
        for (int i = EDGE_DST; i < `VMEM_DEPTH; i++) read_check(i * 4);
        read_check(0);
    endtask

    initial begin
        rng_q      = 32'd57705;
        value_errs = 0;
        other_errs = 0;
        rst_n      = 1'b0;
        start      = 1'b0;
        cmd        = '0;
        host_req   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_idle_check();
        for (int i = 0; i < `VMEM_DEPTH; i++) write_word(i * 4, 4'hf, fill_word(i));
        host_rw_random();
        host_out_of_range();
        block_copy();
        zero_length_copy();
        copy_past_end();
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vmem_copy.f
+incdir+include
logic/vmem_bus_pkg.sv
logic/vmem_ctrl_pkg.sv
logic/vmem_latency_ram.sv
logic/vmem_word_counter.sv
logic/vmem_copy_fsm.sv
logic/vmem_copy_top.sv
sim/vmem_copy_tb.sv

//--- Bender.yml
package:
  name: vmem_copy

export_include_dirs:
  - include

sources:
  - logic/vmem_bus_pkg.sv
  - logic/vmem_ctrl_pkg.sv
  - logic/vmem_latency_ram.sv
  - logic/vmem_word_counter.sv
  - logic/vmem_copy_fsm.sv
  - logic/vmem_copy_top.sv
  - target: simulation
    files:
      - sim/vmem_copy_tb.sv
